//--- verilog/backend_pkg.sv
// shared widths, RV32 opcode constants and payload structs; valid/done must stay the lowest bit
package backend_pkg;

    localparam int xlen       = 32;
    localparam int tag_w      = 8;
    localparam int mul_stages = 2;

    // major opcodes and funct7 classes of the supported subset
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] funct7_base   = 7'b0000000;
    localparam logic [6:0] funct7_alt    = 7'b0100000;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_e;

    typedef enum logic {
        unit_alu,
        unit_mul
    } unit_e;

    // valid last so it lands on bit 0
    typedef struct packed {
        logic [xlen-1:0]  pc;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  operand_b;
        logic [xlen-1:0]  operand_a;
        alu_op_e          op;
        unit_e            unit;
        logic             valid;
    } micro_op_t;

    typedef struct packed {
        logic [xlen-1:0]  pc;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
        logic             done;
    } lane_result_t;

    // mul lane occupies the low bits, so bit 0 is mul.done
    typedef struct packed {
        lane_result_t alu;
        lane_result_t mul;
    } completion_t;

endpackage

//--- verilog/decode_stage.sv
// RV32 subset only (OP, OP-IMM arithmetic, MUL); sltu, sra, shifts-immediate and all else are illegal
`timescale 1ns/1ps

module decode_stage (
    input  logic                                in_valid,
    input  logic [31:0]                         instruction,
    input  logic [backend_pkg::xlen-1:0]        pc,
    input  logic [backend_pkg::xlen-1:0]        rs1_data,
    input  logic [backend_pkg::xlen-1:0]        rs2_data,
    input  logic [backend_pkg::tag_w-1:0]       dest_tag,
    output backend_pkg::micro_op_t              uop,
    output logic                                illegal
);

    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic [backend_pkg::xlen-1:0] imm_i;
    logic                        legal;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    // sign-extended I-type immediate
    assign imm_i  = {{(backend_pkg::xlen-12){instruction[31]}}, instruction[31:20]};

    always_comb begin
        legal         = 1'b0;
        uop.pc        = pc;
        uop.tag       = dest_tag;
        uop.operand_a = rs1_data;
        uop.operand_b = rs2_data;
        uop.op        = backend_pkg::alu_add;
        uop.unit      = backend_pkg::unit_alu;
        case (opcode)
            backend_pkg::opcode_op: begin
                if (funct7 == backend_pkg::funct7_base) begin
                    legal = 1'b1;
                    case (funct3)
                        3'b000:  uop.op = backend_pkg::alu_add;
                        3'b001:  uop.op = backend_pkg::alu_sll;
                        3'b010:  uop.op = backend_pkg::alu_slt;
                        3'b100:  uop.op = backend_pkg::alu_xor;
                        3'b101:  uop.op = backend_pkg::alu_srl;
                        3'b110:  uop.op = backend_pkg::alu_or;
                        3'b111:  uop.op = backend_pkg::alu_and;
                        default: legal = 1'b0;
                    endcase
                end else if (funct7 == backend_pkg::funct7_alt && funct3 == 3'b000) begin
                    legal  = 1'b1;
                    uop.op = backend_pkg::alu_sub;
                end else if (funct7 == backend_pkg::funct7_muldiv && funct3 == 3'b000) begin
                    legal    = 1'b1;
                    uop.unit = backend_pkg::unit_mul;
                end
            end
            backend_pkg::opcode_op_imm: begin
                uop.operand_b = imm_i;
                legal         = 1'b1;
                case (funct3)
                    3'b000:  uop.op = backend_pkg::alu_add;
                    3'b010:  uop.op = backend_pkg::alu_slt;
                    3'b100:  uop.op = backend_pkg::alu_xor;
                    3'b110:  uop.op = backend_pkg::alu_or;
                    3'b111:  uop.op = backend_pkg::alu_and;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        uop.valid = in_valid & legal;
    end

    // flagged in the same cycle the instruction is presented
    assign illegal = in_valid & ~legal;

endmodule

//--- verilog/stage_register.sv
// payload must be a packed type whose bit 0 is its valid/done flag; flush beats stall
`timescale 1ns/1ps

module stage_register #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // flush inserts an all-zero bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    // nothing survives a flush into the following cycle
    flush_leaves_bubble: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !(|q[0])
    ) else $error("stage_register: valid/done set after flush");

endmodule

//--- verilog/mul_pipe.sv
// fixed two-stage multiplier returning the low 32 product bits; depth must match mul_stages
`timescale 1ns/1ps

module mul_pipe (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      flush,
    input  backend_pkg::micro_op_t    issue,
    output backend_pkg::lane_result_t result
);

    logic                          s1_valid;
    logic [backend_pkg::xlen-1:0]  s1_a;
    logic [backend_pkg::xlen-1:0]  s1_b;
    logic [backend_pkg::tag_w-1:0] s1_tag;
    logic [backend_pkg::xlen-1:0]  s1_pc;
    logic                          s2_done;
    logic [backend_pkg::xlen-1:0]  s2_value;
    logic [backend_pkg::tag_w-1:0] s2_tag;
    logic [backend_pkg::xlen-1:0]  s2_pc;
    logic [2*backend_pkg::xlen-1:0] product;

    if (backend_pkg::mul_stages != 2) begin : g_depth_check
        $error("mul_pipe implements exactly two stages");
    end

    assign product = s1_a * s1_b;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_done  <= 1'b0;
        end else if (flush) begin
            s1_valid <= 1'b0;
            s2_done  <= 1'b0;
        end else if (!stall) begin
            s1_valid <= issue.valid;
            s2_done  <= s1_valid;
        end
    end

    // operands, tag and pc ride alongside the valid bits
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_a     <= issue.operand_a;
            s1_b     <= issue.operand_b;
            s1_tag   <= issue.tag;
            s1_pc    <= issue.pc;
            s2_value <= product[backend_pkg::xlen-1:0];
            s2_tag   <= s1_tag;
            s2_pc    <= s1_pc;
        end
    end

    assign result.done  = s2_done;
    assign result.value = s2_value;
    assign result.tag   = s2_tag;
    assign result.pc    = s2_pc;

    done_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(result.done)
    ) else $error("mul_pipe: result.done unknown");

endmodule

//--- verilog/execute_cluster.sv
// single-cycle ALU lane plus pipelined MUL lane; no sra, sltu or divide support
`timescale 1ns/1ps

module execute_cluster (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   flush,
    input  backend_pkg::micro_op_t uop,
    output backend_pkg::completion_t next_completion
);

    logic                         alu_sel;
    logic                         mul_sel;
    logic [4:0]                   shamt;
    logic [backend_pkg::xlen-1:0] alu_value;
    backend_pkg::micro_op_t       mul_issue;
    backend_pkg::lane_result_t    mul_result;

    assign alu_sel = uop.valid && (uop.unit == backend_pkg::unit_alu);
    assign mul_sel = uop.valid && (uop.unit == backend_pkg::unit_mul);
    assign shamt   = uop.operand_b[4:0];

    always_comb begin
        case (uop.op)
            backend_pkg::alu_add: alu_value = uop.operand_a + uop.operand_b;
            backend_pkg::alu_sub: alu_value = uop.operand_a - uop.operand_b;
            backend_pkg::alu_and: alu_value = uop.operand_a & uop.operand_b;
            backend_pkg::alu_or:  alu_value = uop.operand_a | uop.operand_b;
            backend_pkg::alu_xor: alu_value = uop.operand_a ^ uop.operand_b;
            backend_pkg::alu_slt: begin
                alu_value = {{(backend_pkg::xlen-1){1'b0}},
                             $signed(uop.operand_a) < $signed(uop.operand_b)};
            end
            backend_pkg::alu_sll: alu_value = uop.operand_a << shamt;
            backend_pkg::alu_srl: alu_value = uop.operand_a >> shamt;
            default:              alu_value = '0;
        endcase
    end

    // only mul micro-ops reach the multiplier
    always_comb begin
        mul_issue       = uop;
        mul_issue.valid = mul_sel;
    end

    mul_pipe u_mul_pipe (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .flush  (flush),
        .issue  (mul_issue),
        .result (mul_result)
    );

    assign next_completion.alu.done  = alu_sel;
    assign next_completion.alu.value = alu_value;
    assign next_completion.alu.tag   = uop.tag;
    assign next_completion.alu.pc    = uop.pc;
    assign next_completion.mul       = mul_result;

    one_lane_per_uop: assert property (
        @(posedge clk) disable iff (reset)
        uop.valid |-> (alu_sel ^ mul_sel)
    ) else $error("execute_cluster: uop steered to both or no lanes");

endmodule

//--- verilog/backend_top.sv
// back end only: operands arrive already read, no regfile, rename or ROB; count done only when unstalled
`timescale 1ns/1ps

module backend_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  logic [31:0]                   instruction,
    input  logic [backend_pkg::xlen-1:0]  pc,
    input  logic [backend_pkg::xlen-1:0]  rs1_data,
    input  logic [backend_pkg::xlen-1:0]  rs2_data,
    input  logic [backend_pkg::tag_w-1:0] dest_tag,
    input  logic                          stall,
    input  logic                          flush,
    output backend_pkg::completion_t      completion,
    output logic                          illegal,
    output logic                          in_ready
);

    backend_pkg::micro_op_t   dec_uop;
    backend_pkg::micro_op_t   issue_uop;
    backend_pkg::completion_t next_completion;

    assign in_ready = ~stall;

    decode_stage u_decode (
        .in_valid    (in_valid),
        .instruction (instruction),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dest_tag    (dest_tag),
        .uop         (dec_uop),
        .illegal     (illegal)
    );

    stage_register #(.payload_t(backend_pkg::micro_op_t)) u_issue_reg (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .d     (dec_uop),
        .q     (issue_uop)
    );

    execute_cluster u_execute (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .flush           (flush),
        .uop             (issue_uop),
        .next_completion (next_completion)
    );

    // results leaving at a flush edge still retire, even under stall
    stage_register #(.payload_t(backend_pkg::completion_t)) u_complete_reg (
        .clk   (clk),
        .reset (reset),
        .stall (stall & ~flush),
        .flush (1'b0),
        .d     (next_completion),
        .q     (completion)
    );

endmodule

//--- test/tb_clock.sv
// free-running 40 ns clock; reset is high from time zero through the second rising edge
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int half_period_ns = 20;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

    always #(half_period_ns) clk = ~clk;

endmodule

//--- test/tb_backend.sv
// stall and flush are exercised in separate tests; a flush during a stalled done cycle is not modeled
`timescale 1ns/1ps

module tb_backend;

    localparam int clock_period_ns = 40;
    localparam int n_alu           = 40;
    localparam int n_mul           = 40;
    localparam int n_stall         = 60;
    localparam int n_flush         = 60;
    localparam int n_illegal       = 30;
    localparam int total_ops       = n_alu + n_mul + n_stall + n_flush + n_illegal;
    localparam int watchdog_ns     = total_ops * 8 * clock_period_ns;

    typedef struct packed {
        int                        accept_edge;
        backend_pkg::lane_result_t res;
    } expect_t;

    typedef struct packed {
        logic        legal;
        logic        is_mul;
        logic [31:0] value;
    } ref_t;

    logic                          clk;
    logic                          reset;
    logic                          in_valid;
    logic [31:0]                   instruction;
    logic [backend_pkg::xlen-1:0]  pc;
    logic [backend_pkg::xlen-1:0]  rs1_data;
    logic [backend_pkg::xlen-1:0]  rs2_data;
    logic [backend_pkg::tag_w-1:0] dest_tag;
    logic                          stall;
    logic                          flush;
    backend_pkg::completion_t      completion;
    logic                          illegal;
    logic                          in_ready;

    int          pass_count = 0;
    int          fail_count = 0;
    int          edge_count = 0;
    int unsigned seed;
    int unsigned rand_word;
    expect_t     alu_q[$];
    expect_t     mul_q[$];

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    backend_top dut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .instruction (instruction),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dest_tag    (dest_tag),
        .stall       (stall),
        .flush       (flush),
        .completion  (completion),
        .illegal     (illegal),
        .in_ready    (in_ready)
    );

    // RV32 subset: OP base/sub/mul and OP-IMM addi, slti, xori, ori, andi
    function automatic ref_t reference_decode(input logic [31:0] w, input logic [31:0] a,
                                              input logic [31:0] b);
        ref_t        r;
        logic        is_reg;
        logic [31:0] rhs;
        r      = '0;
        is_reg = (w[6:0] == 7'b0110011);
        rhs    = is_reg ? b : {{20{w[31]}}, w[31:20]};
        if (is_reg && w[31:25] == 7'b0000001 && w[14:12] == 3'b000) begin
            r.legal  = 1'b1;
            r.is_mul = 1'b1;
            r.value  = a * b;
        end else if (is_reg && w[31:25] == 7'b0100000 && w[14:12] == 3'b000) begin
            r.legal = 1'b1;
            r.value = a - b;
        end else if ((is_reg && w[31:25] == 7'b0000000) || w[6:0] == 7'b0010011) begin
            r.legal = 1'b1;
            case (w[14:12])
                3'b000:  r.value = a + rhs;
                3'b010:  r.value = ($signed(a) < $signed(rhs)) ? 32'd1 : 32'd0;
                3'b100:  r.value = a ^ rhs;
                3'b110:  r.value = a | rhs;
                3'b111:  r.value = a & rhs;
                3'b001:  r.value = a << rhs[4:0];
                3'b101:  r.value = a >> rhs[4:0];
                default: r.legal = 1'b0;
            endcase
            // no immediate shifts in the subset
            if (!is_reg && w[13:12] == 2'b01) begin
                r.legal = 1'b0;
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] random_alu_instruction();
        logic [31:0] w;
        logic [2:0]  f3;
        w  = $urandom;
        f3 = $urandom_range(7, 0);
        if ($urandom_range(1, 0) == 1) begin
            // funct3 3 (sltu) is turned into sub
            w[6:0]   = 7'b0110011;
            w[31:25] = (f3 == 3'd3) ? 7'b0100000 : 7'b0000000;
            w[14:12] = (f3 == 3'd3) ? 3'd0 : f3;
        end else begin
            w[6:0]   = 7'b0010011;
            w[14:12] = (f3[0] && f3 != 3'd7) ? f3 - 3'd1 : f3;
        end
        return w;
    endfunction

    function automatic logic [31:0] random_mul_instruction();
        logic [31:0] w;
        w        = $urandom;
        w[6:0]   = 7'b0110011;
        w[14:12] = 3'b000;
        w[31:25] = 7'b0000001;
        return w;
    endfunction

    function automatic logic [31:0] random_illegal_instruction();
        logic [31:0] w;
        ref_t        r;
        do begin
            w = $urandom;
            if ($urandom_range(1, 0) == 1) begin
                w[6:0] = 7'b0110011;
            end
            r = reference_decode(w, 32'd0, 32'd0);
        end while (r.legal);
        return w;
    endfunction

    task automatic note_failure(input string msg);
        fail_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic compare_lane(input string name, input backend_pkg::lane_result_t expected,
                                input backend_pkg::lane_result_t actual);
        if (actual !== expected) begin
            fail_count++;
            $display("Mismatch at %0t: %s expected %h tag %h pc %h, actual %h tag %h pc %h",
                     $time, name, expected.value, expected.tag, expected.pc,
                     actual.value, actual.tag, actual.pc);
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_count++;
            $display("Mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_lane_result(input logic is_mul, input backend_pkg::lane_result_t got);
        expect_t e;
        int      latency;
        string   name;
        name    = is_mul ? "completion.mul" : "completion.alu";
        latency = is_mul ? 1 + backend_pkg::mul_stages : 1;
        if ((is_mul && mul_q.size() == 0) || (!is_mul && alu_q.size() == 0)) begin
            note_failure($sformatf("%s done with nothing outstanding, tag %h", name, got.tag));
        end else begin
            if (is_mul) begin
                e = mul_q.pop_front();
            end else begin
                e = alu_q.pop_front();
            end
            if (e.accept_edge + latency != edge_count) begin
                note_failure($sformatf("%s tag %h arrived at edge %0d instead of edge %0d",
                                       name, got.tag, edge_count, e.accept_edge + latency));
            end
            compare_lane(name, e.res, got);
        end
    endtask

    // alu entries have always completed by the time a later flush edge arrives
    task automatic drop_flushed(input int flush_edge);
        int i;
        for (i = mul_q.size() - 1; i >= 0; i--) begin
            if (flush_edge < mul_q[i].accept_edge + 1 + backend_pkg::mul_stages) begin
                mul_q.delete(i);
            end
        end
    endtask

    // outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin : monitor
        ref_t    r;
        expect_t e;
        if (!reset) begin
            compare_flag("in_ready", !stall, in_ready);
            r = reference_decode(instruction, rs1_data, rs2_data);
            compare_flag("illegal", in_valid && !r.legal, illegal);
            if (!stall && completion.alu.done) begin
                check_lane_result(1'b0, completion.alu);
            end
            if (!stall && completion.mul.done) begin
                check_lane_result(1'b1, completion.mul);
            end
            // the coming rising edge moves the pipeline
            if (!stall || flush) begin
                edge_count++;
                if (flush) begin
                    drop_flushed(edge_count);
                end
                if (in_valid && !stall && !flush && r.legal) begin
                    e.accept_edge = edge_count;
                    e.res.done    = 1'b1;
                    e.res.value   = r.value;
                    e.res.tag     = dest_tag;
                    e.res.pc      = pc;
                    if (r.is_mul) begin
                        mul_q.push_back(e);
                    end else begin
                        alu_q.push_back(e);
                    end
                end
            end
        end
    end

    task automatic drive_cycle(input logic valid, input logic [31:0] instr, input logic hold,
                               input logic kill);
        @(posedge clk);
        in_valid    <= valid;
        instruction <= instr;
        pc          <= $urandom & 32'hffff_fffc;
        rs1_data    <= $urandom;
        rs2_data    <= $urandom;
        dest_tag    <= $urandom;
        stall       <= hold;
        flush       <= kill;
    endtask

    // mode 0 alu, 1 mul stream, 2 stall, 3 flush, 4 illegal
    task automatic run_test(input string name, input int mode, input int n_ops);
        int          fails_before;
        int          waited;
        int          i;
        logic [31:0] instr;
        fails_before = fail_count;
        for (i = 0; i < n_ops; i++) begin
            case (mode)
                0:       instr = random_alu_instruction();
                1:       instr = ($urandom_range(2, 0) == 0) ? random_alu_instruction()
                                                             : random_mul_instruction();
                4:       instr = random_illegal_instruction();
                default: instr = ($urandom_range(1, 0) == 0) ? random_alu_instruction()
                                                             : random_mul_instruction();
            endcase
            if (mode == 2 && $urandom_range(3, 0) == 0) begin
                repeat ($urandom_range(5, 1)) begin
                    drive_cycle(1'b1, random_alu_instruction(), 1'b1, 1'b0);
                end
            end
            drive_cycle(mode != 0 || $urandom_range(4, 0) != 0, instr, 1'b0,
                        mode == 3 && $urandom_range(4, 0) == 0);
        end
        waited = 0;
        do begin
            drive_cycle(1'b0, 32'd0, 1'b0, 1'b0);
            waited++;
        end while ((alu_q.size() != 0 || mul_q.size() != 0) && waited < 12);
        if (alu_q.size() != 0 || mul_q.size() != 0) begin
            note_failure($sformatf("%0d results never arrived", alu_q.size() + mul_q.size()));
            alu_q.delete();
            mul_q.delete();
        end
        $display("test %s: %s, %0d failures", name,
                 (fail_count == fails_before) ? "ok" : "FAILED", fail_count - fails_before);
    endtask

    initial begin
        #(watchdog_ns);
        $display("Error: watchdog expired after %0d ns, the run is stuck", watchdog_ns);
        $display("sim failed");
        $finish;
    end

    initial begin
        seed        = 32'hfb966338;
        rand_word   = $urandom(seed);
        in_valid    = 1'b0;
        instruction = 32'd0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        dest_tag    = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        wait (reset === 1'b0);
        run_test("alu mix", 0, n_alu);
        run_test("multiplier stream", 1, n_mul);
        run_test("back-pressure", 2, n_stall);
        run_test("flush", 3, n_flush);
        run_test("illegal encodings", 4, n_illegal);
        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sim.f
verilog/backend_pkg.sv
verilog/decode_stage.sv
verilog/stage_register.sv
verilog/mul_pipe.sv
verilog/execute_cluster.sv
verilog/backend_top.sv
test/tb_clock.sv
test/tb_backend.sv
